// ==== Bender.yml ====
package:
  name: eth_demux

sources:
  - eth_demux_pkg.sv
  - eth_payload_if.sv
  - frame_steer.sv
  - payload_skid.sv
  - eth_demux_top.sv
  - target: simulation
    files:
      - tb_eth_demux.sv

// ==== eth_demux_pkg.sv ====
// eth demux shared types
// payload word, header field and frame state definitions used across the design

package eth_demux_pkg;

    // payload word width in bits
    localparam int data_width = 64;

    // one byte enable per payload byte
    localparam int keep_width = data_width / 8;

    // one payload word and its byte enables
    typedef logic [data_width-1:0] payload_data_t;
    typedef logic [keep_width-1:0] payload_keep_t;

    // ethernet header fields
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;

    // frame tracking in the steering logic
    // idle waits for a header, active forwards payload until tlast
    typedef enum logic {
        frame_idle,
        frame_active
    } frame_state_t;

endpackage

// ==== eth_demux_top.sv ====
// ethernet frame demultiplexer
// steers each input frame, header and 64-bit payload, to one of num_ports outputs

`timescale 1ns/1ps

module eth_demux_top
    import eth_demux_pkg::*;
#(
    parameter int num_ports = 4
) (
    input  logic                         clk,
    input  logic                         rst,

    // control
    input  logic                         enable,
    input  logic [$clog2(num_ports)-1:0] select,

    // input header
    input  logic                         in_hdr_valid,
    output logic                         in_hdr_ready,
    input  mac_addr_t                    in_dest_mac,
    input  mac_addr_t                    in_src_mac,
    input  eth_type_t                    in_eth_type,

    // input payload
    input  payload_data_t                in_payload_tdata,
    input  payload_keep_t                in_payload_tkeep,
    input  logic                         in_payload_tvalid,
    output logic                         in_payload_tready,
    input  logic                         in_payload_tlast,
    input  logic                         in_payload_tuser,

    // output headers, fields shared by all ports
    output logic [num_ports-1:0]         out_hdr_valid,
    input  logic [num_ports-1:0]         out_hdr_ready,
    output mac_addr_t                    out_dest_mac,
    output mac_addr_t                    out_src_mac,
    output eth_type_t                    out_eth_type,

    // output payload, fields shared by all ports
    output payload_data_t                out_payload_tdata,
    output payload_keep_t                out_payload_tkeep,
    output logic [num_ports-1:0]         out_payload_tvalid,
    input  logic [num_ports-1:0]         out_payload_tready,
    output logic                         out_payload_tlast,
    output logic                         out_payload_tuser
);

    logic port_busy;

    eth_payload_if #(
        .num_ports(num_ports)
    ) pl_if ();

    frame_steer #(
        .num_ports(num_ports)
    ) u_frame_steer (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .select            (select),
        .in_hdr_valid      (in_hdr_valid),
        .in_hdr_ready      (in_hdr_ready),
        .in_dest_mac       (in_dest_mac),
        .in_src_mac        (in_src_mac),
        .in_eth_type       (in_eth_type),
        .in_payload_tdata  (in_payload_tdata),
        .in_payload_tkeep  (in_payload_tkeep),
        .in_payload_tvalid (in_payload_tvalid),
        .in_payload_tready (in_payload_tready),
        .in_payload_tlast  (in_payload_tlast),
        .in_payload_tuser  (in_payload_tuser),
        .out_hdr_valid     (out_hdr_valid),
        .out_hdr_ready     (out_hdr_ready),
        .out_dest_mac      (out_dest_mac),
        .out_src_mac       (out_src_mac),
        .out_eth_type      (out_eth_type),
        .port_busy         (port_busy),
        .pl                (pl_if.steer)
    );

    payload_skid #(
        .num_ports(num_ports)
    ) u_payload_skid (
        .clk                (clk),
        .rst                (rst),
        .pl                 (pl_if.skid),
        .out_payload_tdata  (out_payload_tdata),
        .out_payload_tkeep  (out_payload_tkeep),
        .out_payload_tvalid (out_payload_tvalid),
        .out_payload_tready (out_payload_tready),
        .out_payload_tlast  (out_payload_tlast),
        .out_payload_tuser  (out_payload_tuser),
        .port_busy          (port_busy)
    );

endmodule

// ==== eth_payload_if.sv ====
// eth payload interface
// accepted payload beat from the frame steering logic to the output skid buffer

`timescale 1ns/1ps

interface eth_payload_if
    import eth_demux_pkg::*;
#(
    parameter int num_ports = 4
) ();

    localparam int port_width = $clog2(num_ports);

    // beat fields, valid only for a beat accepted at the input
    payload_data_t         tdata;
    payload_keep_t         tkeep;
    logic                  tvalid;
    logic                  tlast;
    logic                  tuser;

    // skid buffer can take a beat two cycles ahead
    logic                  ready_early;

    // output port the current frame is steered to
    logic [port_width-1:0] port;

    modport steer (
        output tdata,
        output tkeep,
        output tvalid,
        output tlast,
        output tuser,
        output port,
        input  ready_early
    );

    modport skid (
        input  tdata,
        input  tkeep,
        input  tvalid,
        input  tlast,
        input  tuser,
        input  port,
        output ready_early
    );

endinterface

// ==== frame_steer.sv ====
// frame steering
// samples select at frame start, registers the header and hands it to one port,
// then gates the input payload stream until the end of the frame

`timescale 1ns/1ps

module frame_steer
    import eth_demux_pkg::*;
#(
    parameter int num_ports = 4
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         enable,
    input  logic [$clog2(num_ports)-1:0] select,

    // input header
    input  logic                         in_hdr_valid,
    output logic                         in_hdr_ready,
    input  mac_addr_t                    in_dest_mac,
    input  mac_addr_t                    in_src_mac,
    input  eth_type_t                    in_eth_type,

    // input payload stream
    input  payload_data_t                in_payload_tdata,
    input  payload_keep_t                in_payload_tkeep,
    input  logic                         in_payload_tvalid,
    output logic                         in_payload_tready,
    input  logic                         in_payload_tlast,
    input  logic                         in_payload_tuser,

    // per-port header handover
    output logic [num_ports-1:0]         out_hdr_valid,
    input  logic [num_ports-1:0]         out_hdr_ready,
    output mac_addr_t                    out_dest_mac,
    output mac_addr_t                    out_src_mac,
    output eth_type_t                    out_eth_type,

    // payload valid of the currently selected port
    input  logic                         port_busy,

    eth_payload_if.steer                 pl
);

    localparam int port_width = $clog2(num_ports);

    frame_state_t          state_reg;
    frame_state_t          state_next;
    logic [port_width-1:0] select_reg;
    logic                  hdr_ready_reg;
    logic                  hdr_ready_next;
    logic                  payload_ready_reg;
    logic [num_ports-1:0]  hdr_valid_reg;
    logic [num_ports-1:0]  hdr_valid_next;
    logic                  frame_start;
    logic                  beat_accepted;

    mac_addr_t             dest_mac_reg;
    mac_addr_t             src_mac_reg;
    eth_type_t             eth_type_reg;

    assign beat_accepted = in_payload_tvalid & payload_ready_reg;

    // header and payload registers are shared by all ports, so the current
    // port must hand off its header and drain its payload before select moves
    assign frame_start = (state_reg == frame_idle) & enable & in_hdr_valid &
                         ~hdr_valid_reg[select_reg] & ~port_busy;

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            frame_idle: begin
                if (frame_start) begin
                    state_next = frame_active;
                end
            end
            frame_active: begin
                // end of frame on the accepted tlast beat
                if (beat_accepted & in_payload_tlast) begin
                    state_next = frame_idle;
                end
            end
        endcase
    end

    always_comb begin
        // header valid holds until the port takes it
        hdr_valid_next = hdr_valid_reg & ~out_hdr_ready;
        if (frame_start) begin
            hdr_valid_next[select] = 1'b1;
        end
        // input header ready is a single cycle pulse after frame start
        hdr_ready_next = (hdr_ready_reg & ~in_hdr_valid) | frame_start;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_reg         <= frame_idle;
            select_reg        <= '0;
            hdr_ready_reg     <= 1'b0;
            payload_ready_reg <= 1'b0;
            hdr_valid_reg     <= '0;
        end else begin
            state_reg         <= state_next;
            hdr_ready_reg     <= hdr_ready_next;
            hdr_valid_reg     <= hdr_valid_next;
            payload_ready_reg <= pl.ready_early & (state_next == frame_active);
            if (frame_start) begin
                select_reg <= select;
            end
        end
    end

    // header fields captured at frame start
    always_ff @(posedge clk) begin
        if (frame_start) begin
            dest_mac_reg <= in_dest_mac;
            src_mac_reg  <= in_src_mac;
            eth_type_reg <= in_eth_type;
        end
    end

    assign in_hdr_ready      = hdr_ready_reg;
    assign in_payload_tready = payload_ready_reg;
    assign out_hdr_valid     = hdr_valid_reg;
    assign out_dest_mac      = dest_mac_reg;
    assign out_src_mac       = src_mac_reg;
    assign out_eth_type      = eth_type_reg;

    // only beats accepted at the input are passed on
    assign pl.tdata  = in_payload_tdata;
    assign pl.tkeep  = in_payload_tkeep;
    assign pl.tvalid = beat_accepted;
    assign pl.tlast  = in_payload_tlast;
    assign pl.tuser  = in_payload_tuser;
    assign pl.port   = select_reg;

endmodule

// ==== payload_skid.sv ====
// payload skid buffer
// registered per-port payload output with a one-entry overflow register,
// keeps full throughput while the selected port applies back-pressure

`timescale 1ns/1ps

module payload_skid
    import eth_demux_pkg::*;
#(
    parameter int num_ports = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    eth_payload_if.skid          pl,

    // shared payload fields, per-port valid and ready
    output payload_data_t        out_payload_tdata,
    output payload_keep_t        out_payload_tkeep,
    output logic [num_ports-1:0] out_payload_tvalid,
    input  logic [num_ports-1:0] out_payload_tready,
    output logic                 out_payload_tlast,
    output logic                 out_payload_tuser,

    output logic                 port_busy
);

    logic [num_ports-1:0] valid_reg;
    payload_data_t        out_data_reg;
    payload_keep_t        out_keep_reg;
    logic                 out_last_reg;
    logic                 out_user_reg;

    // overflow entry
    payload_data_t        temp_data_reg;
    payload_keep_t        temp_keep_reg;
    logic                 temp_valid_reg;
    logic                 temp_last_reg;
    logic                 temp_user_reg;

    logic                 in_ready_reg;
    logic                 cur_ready;
    logic                 cur_valid;
    logic                 load_out_from_in;
    logic                 load_out_from_temp;
    logic                 load_temp;

    assign cur_ready = out_payload_tready[pl.port];
    assign cur_valid = valid_reg[pl.port];

    // room two cycles out if the port drains now, if both registers are
    // free, or if the overflow is free and will not be filled this cycle
    assign pl.ready_early = cur_ready |
                            (~temp_valid_reg & ~cur_valid) |
                            (~temp_valid_reg & ~pl.tvalid);

    // input side open: overflow is known to be empty here
    assign load_out_from_in = in_ready_reg & (cur_ready | ~cur_valid);
    assign load_temp        = in_ready_reg & ~cur_ready & cur_valid;
    // input side closed: let the overflow catch up with the port
    assign load_out_from_temp = ~in_ready_reg & cur_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_reg      <= '0;
            temp_valid_reg <= 1'b0;
            in_ready_reg   <= 1'b0;
        end else begin
            in_ready_reg <= pl.ready_early;
            if (load_out_from_in) begin
                valid_reg[pl.port] <= pl.tvalid;
            end else if (load_out_from_temp) begin
                valid_reg[pl.port] <= temp_valid_reg;
                temp_valid_reg     <= 1'b0;
            end
            if (load_temp) begin
                temp_valid_reg <= pl.tvalid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_data_reg <= pl.tdata;
            out_keep_reg <= pl.tkeep;
            out_last_reg <= pl.tlast;
            out_user_reg <= pl.tuser;
        end else if (load_out_from_temp) begin
            out_data_reg <= temp_data_reg;
            out_keep_reg <= temp_keep_reg;
            out_last_reg <= temp_last_reg;
            out_user_reg <= temp_user_reg;
        end
        if (load_temp) begin
            temp_data_reg <= pl.tdata;
            temp_keep_reg <= pl.tkeep;
            temp_last_reg <= pl.tlast;
            temp_user_reg <= pl.tuser;
        end
    end

    assign out_payload_tdata  = out_data_reg;
    assign out_payload_tkeep  = out_keep_reg;
    assign out_payload_tvalid = valid_reg;
    assign out_payload_tlast  = out_last_reg;
    assign out_payload_tuser  = out_user_reg;

    // a pending beat on the selected port blocks the next frame start
    assign port_busy = cur_valid;

endmodule

// ==== sim.f ====
eth_demux_pkg.sv
eth_payload_if.sv
frame_steer.sv
payload_skid.sv
eth_demux_top.sv
tb_eth_demux.sv

// ==== tb_eth_demux.sv ====
// testbench for the ethernet frame demultiplexer
// drives random frames, builds expected per-port traffic and checks every handshake

`timescale 1ns/1ps

module tb_eth_demux;
    import eth_demux_pkg::*;

    localparam int num_ports = 4;
    localparam int max_len = 8;
    localparam int max_frames = 4 + 1 + 2 + 40;
    // 20 cycles per beat, plus headroom for the enable test and reset
    localparam int timeout_cycles = max_frames * max_len * 20 + 1000;

    logic clk;
    logic rst;
    logic enable;
    logic [$clog2(num_ports)-1:0] select;
    logic in_hdr_valid;
    logic in_hdr_ready;
    mac_addr_t in_dest_mac;
    mac_addr_t in_src_mac;
    eth_type_t in_eth_type;
    payload_data_t in_payload_tdata;
    payload_keep_t in_payload_tkeep;
    logic in_payload_tvalid;
    logic in_payload_tready;
    logic in_payload_tlast;
    logic in_payload_tuser;
    logic [num_ports-1:0] out_hdr_valid;
    logic [num_ports-1:0] out_hdr_ready;
    mac_addr_t out_dest_mac;
    mac_addr_t out_src_mac;
    eth_type_t out_eth_type;
    payload_data_t out_payload_tdata;
    payload_keep_t out_payload_tkeep;
    logic [num_ports-1:0] out_payload_tvalid;
    logic [num_ports-1:0] out_payload_tready;
    logic out_payload_tlast;
    logic out_payload_tuser;

    // stimulus frames, beats of frame f start at f_first[f]
    int f_sel[max_frames];
    mac_addr_t f_dest[max_frames];
    mac_addr_t f_src[max_frames];
    eth_type_t f_type[max_frames];
    int f_len[max_frames];
    int f_first[max_frames];
    payload_data_t b_data[max_frames*max_len];
    payload_keep_t b_keep[max_frames*max_len];
    logic b_user[max_frames*max_len];
    int n_frames = 0;
    int n_beats = 0;

    // expected traffic, in order per port
    int eh_port[$];
    mac_addr_t eh_dest[$];
    mac_addr_t eh_src[$];
    eth_type_t eh_type[$];
    int eb_port[$];
    payload_data_t eb_data[$];
    payload_keep_t eb_keep[$];
    logic eb_last[$];
    logic eb_user[$];

    string cur_test;
    int err_count = 0;
    int test_errs = 0;
    int test_count = 0;
    logic backpressure = 1'b0;

    eth_demux_top #(
        .num_ports(num_ports)
    ) uut (
        .clk(clk), .rst(rst), .enable(enable), .select(select),
        .in_hdr_valid(in_hdr_valid), .in_hdr_ready(in_hdr_ready),
        .in_dest_mac(in_dest_mac), .in_src_mac(in_src_mac), .in_eth_type(in_eth_type),
        .in_payload_tdata(in_payload_tdata), .in_payload_tkeep(in_payload_tkeep),
        .in_payload_tvalid(in_payload_tvalid), .in_payload_tready(in_payload_tready),
        .in_payload_tlast(in_payload_tlast), .in_payload_tuser(in_payload_tuser),
        .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
        .out_dest_mac(out_dest_mac), .out_src_mac(out_src_mac), .out_eth_type(out_eth_type),
        .out_payload_tdata(out_payload_tdata), .out_payload_tkeep(out_payload_tkeep),
        .out_payload_tvalid(out_payload_tvalid), .out_payload_tready(out_payload_tready),
        .out_payload_tlast(out_payload_tlast), .out_payload_tuser(out_payload_tuser)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // adds one random frame to the stimulus list
    function automatic int make_frame(int sel, int len);
        int f;
        f = n_frames;
        f_sel[f] = sel;
        f_dest[f] = {$urandom, $urandom};
        f_src[f] = {$urandom, $urandom};
        f_type[f] = $urandom;
        f_len[f] = len;
        f_first[f] = n_beats;
        for (int i = 0; i < len; i++) begin
            b_data[n_beats] = {$urandom, $urandom};
            b_keep[n_beats] = $urandom;
            b_user[n_beats] = $urandom;
            n_beats++;
        end
        n_frames++;
        return f;
    endfunction

    // reference model, each frame goes whole to the port selected with its header
    function automatic void expected_from_frames(int first, int last);
        for (int f = first; f <= last; f++) begin
            eh_port.push_back(f_sel[f]);
            eh_dest.push_back(f_dest[f]);
            eh_src.push_back(f_src[f]);
            eh_type.push_back(f_type[f]);
            for (int i = 0; i < f_len[f]; i++) begin
                eb_port.push_back(f_sel[f]);
                eb_data.push_back(b_data[f_first[f] + i]);
                eb_keep.push_back(b_keep[f_first[f] + i]);
                eb_last.push_back(i == f_len[f] - 1);
                eb_user.push_back(b_user[f_first[f] + i]);
            end
        end
    endfunction

    // oldest pending header of port p, unless the output header is queued for another port
    function automatic int find_hdr(int p);
        int idx_port;
        int idx_match;
        idx_port = -1;
        idx_match = -1;
        for (int i = eh_port.size() - 1; i >= 0; i--) begin
            if (eh_port[i] == p) idx_port = i;
            if (eh_dest[i] == out_dest_mac && eh_src[i] == out_src_mac &&
                eh_type[i] == out_eth_type) idx_match = i;
        end
        if (idx_match >= 0 && eh_port[idx_match] != p) begin
            return idx_match;
        end
        return idx_port;
    endfunction

    // oldest pending beat of port p, unless the output beat is queued for another port
    function automatic int find_beat(int p);
        int idx_port;
        int idx_match;
        idx_port = -1;
        idx_match = -1;
        for (int i = eb_port.size() - 1; i >= 0; i--) begin
            if (eb_port[i] == p) idx_port = i;
            if (eb_data[i] == out_payload_tdata && eb_keep[i] == out_payload_tkeep)
                idx_match = i;
        end
        if (idx_match >= 0 && eb_port[idx_match] != p) begin
            return idx_match;
        end
        return idx_port;
    endfunction

    task automatic check_hdr(string name, int exp_port, int act_port,
                             mac_addr_t exp_dest, mac_addr_t act_dest,
                             mac_addr_t exp_src, mac_addr_t act_src,
                             eth_type_t exp_type, eth_type_t act_type);
        if (exp_port != act_port || exp_dest != act_dest || exp_src != act_src ||
            exp_type != act_type) begin
            $display("ERR %s header: expected port %0d %h %h %h, actual port %0d %h %h %h",
                     name, exp_port, exp_dest, exp_src, exp_type,
                     act_port, act_dest, act_src, act_type);
            test_errs++;
        end
    endtask

    task automatic check_beat(string name, int exp_port, int act_port,
                              payload_data_t exp_data, payload_data_t act_data,
                              payload_keep_t exp_keep, payload_keep_t act_keep,
                              logic exp_last, logic act_last, logic exp_user, logic act_user);
        if (exp_port != act_port || exp_data != act_data || exp_keep != act_keep ||
            exp_last != act_last || exp_user != act_user) begin
            $display("ERR %s beat: expected port %0d %h %h %b %b, actual port %0d %h %h %b %b",
                     name, exp_port, exp_data, exp_keep, exp_last, exp_user,
                     act_port, act_data, act_keep, act_last, act_user);
            test_errs++;
        end
    endtask

    // records header and payload handshakes on every port
    always @(posedge clk) begin : monitor
        int idx;
        if (!rst) begin
            for (int p = 0; p < num_ports; p++) begin
                if (out_hdr_valid[p] && out_hdr_ready[p]) begin
                    idx = find_hdr(p);
                    if (idx < 0) begin
                        $display("%s: port %0d delivered a header that was not expected",
                                 cur_test, p);
                        test_errs++;
                    end else begin
                        check_hdr(cur_test, eh_port[idx], p, eh_dest[idx], out_dest_mac,
                                  eh_src[idx], out_src_mac, eh_type[idx], out_eth_type);
                        eh_port.delete(idx);
                        eh_dest.delete(idx);
                        eh_src.delete(idx);
                        eh_type.delete(idx);
                    end
                end
                if (out_payload_tvalid[p] && out_payload_tready[p]) begin
                    idx = find_beat(p);
                    if (idx < 0) begin
                        $display("%s: port %0d delivered a beat that was not expected",
                                 cur_test, p);
                        test_errs++;
                    end else begin
                        check_beat(cur_test, eb_port[idx], p, eb_data[idx], out_payload_tdata,
                                   eb_keep[idx], out_payload_tkeep, eb_last[idx],
                                   out_payload_tlast, eb_user[idx], out_payload_tuser);
                        eb_port.delete(idx);
                        eb_data.delete(idx);
                        eb_keep.delete(idx);
                        eb_last.delete(idx);
                        eb_user.delete(idx);
                    end
                end
            end
        end
    end

    // output ready, random while back-pressure is on
    initial begin
        out_hdr_ready = '1;
        out_payload_tready = '1;
        forever begin
            @(posedge clk);
            #1;
            if (backpressure) begin
                out_hdr_ready = $urandom;
                out_payload_tready = $urandom;
            end else begin
                out_hdr_ready = '1;
                out_payload_tready = '1;
            end
        end
    end

    // header handshake then all beats, optionally moving select mid-frame
    task automatic send_frame(int f, int mid_sel);
        select = f_sel[f];
        in_dest_mac = f_dest[f];
        in_src_mac = f_src[f];
        in_eth_type = f_type[f];
        in_hdr_valid = 1'b1;
        do @(posedge clk); while (!in_hdr_ready);
        #1;
        in_hdr_valid = 1'b0;
        if (mid_sel >= 0) select = mid_sel;
        for (int i = 0; i < f_len[f]; i++) begin
            in_payload_tdata = b_data[f_first[f] + i];
            in_payload_tkeep = b_keep[f_first[f] + i];
            in_payload_tuser = b_user[f_first[f] + i];
            in_payload_tlast = (i == f_len[f] - 1);
            in_payload_tvalid = 1'b1;
            do @(posedge clk); while (!in_payload_tready);
            #1;
        end
        in_payload_tvalid = 1'b0;
    endtask

    task automatic finish_test();
        while (eh_port.size() > 0 || eb_port.size() > 0) @(posedge clk);
        repeat (4) @(posedge clk);
        #1;
        $display("test %s: %0d errors", cur_test, test_errs);
        err_count += test_errs;
        test_errs = 0;
        test_count++;
    endtask

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the frames did not drain within %0d cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        int f;
        int first;
        void'($urandom(32'h3d1c_92a8));
        rst = 1'b1;
        enable = 1'b1;
        select = '0;
        in_hdr_valid = 1'b0;
        in_dest_mac = '0;
        in_src_mac = '0;
        in_eth_type = '0;
        in_payload_tdata = '0;
        in_payload_tkeep = '0;
        in_payload_tvalid = 1'b0;
        in_payload_tlast = 1'b0;
        in_payload_tuser = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        cur_test = "reset";
        if (in_hdr_ready || in_payload_tready || out_hdr_valid != 0 ||
            out_payload_tvalid != 0) begin
            $display("%s: a ready or valid output is high after reset", cur_test);
            test_errs++;
        end
        finish_test();

        cur_test = "each_port";
        first = n_frames;
        for (int p = 0; p < num_ports; p++) begin
            f = make_frame(p, 1 + $urandom_range(max_len - 1));
        end
        expected_from_frames(first, n_frames - 1);
        for (int i = first; i < n_frames; i++) send_frame(i, -1);
        finish_test();

        // the pending header must wait while enable is low
        cur_test = "enable_gate";
        f = make_frame(2, 3);
        expected_from_frames(f, f);
        enable = 1'b0;
        select = 2;
        in_hdr_valid = 1'b1;
        repeat (20) begin
            @(posedge clk);
            if (in_hdr_ready || out_hdr_valid != 0 || out_payload_tvalid != 0) begin
                $display("%s: the DUT responded while enable was low", cur_test);
                test_errs++;
            end
        end
        #1;
        enable = 1'b1;
        send_frame(f, -1);
        finish_test();

        cur_test = "select_hold";
        first = make_frame(1, max_len);
        f = make_frame(3, 4);
        expected_from_frames(first, f);
        send_frame(first, 3);
        send_frame(f, -1);
        finish_test();

        cur_test = "backpressure";
        backpressure = 1'b1;
        first = n_frames;
        for (int i = 0; i < 40; i++) begin
            f = make_frame($urandom_range(num_ports - 1), 1 + $urandom_range(max_len - 1));
        end
        expected_from_frames(first, n_frames - 1);
        for (int i = first; i < n_frames; i++) send_frame(i, -1);
        finish_test();
        backpressure = 1'b0;

        $display("%0d tests, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
